// ==== logic/cache_geom_pkg.sv ====
// Geometry of the per-hart data caches.
// Two ways, 256 sets of 8-byte lines over a 17-bit byte address.
// Modules import this for address slicing and for the line type.

package cache_geom_pkg;

    localparam int ADDR_W     = 17;
    localparam int SETS       = 256;
    localparam int LINE_BYTES = 8;

    // address split: tag | index | offset
    localparam int OFFSET_W = 3;   // bits 2..0
    localparam int INDEX_W  = 8;   // bits 10..3
    localparam int TAG_W    = 6;   // bits 16..11

    // one cache line, little-endian
    // words[1] holds bytes 7..4, bytes[i] is the byte at offset i
    typedef union packed {
        logic [1:0][31:0] words;   // reads and word stores
        logic [7:0][7:0]  bytes;   // byte stores
    } line_data_t;

endpackage

// ==== logic/mem_bus_pkg.sv ====
// Main-memory constants shared by the caches, the arbiter and the memory.
// Also holds the 1-bit store-size encoding carried on every size signal.

package mem_bus_pkg;

    localparam int MEM_BYTES   = 131072;  // 128 KiB
    localparam int MEM_LATENCY = 3;       // start to done, in cycles

    // wide enough to hold MEM_LATENCY
    localparam int LAT_CNT_W = $clog2(MEM_LATENCY + 1);

    // store size
    localparam logic SIZE_WORD = 1'b0;
    localparam logic SIZE_BYTE = 1'b1;

endpackage

// ==== logic/data_cache_2way.sv ====
// Write-through, two-way set-associative data cache for one hart.
// Read hits answer in the same cycle. Read misses fetch a full line and
// fill the LRU way. Every write goes to main memory, and a write hit also
// merges into the cached line. A miss on a write does not allocate.
// The hart holds rd/wr, addr and wdata while stall is high.

module data_cache_2way (
    input  logic                              clk,
    input  logic                              rst_n,
    input  logic                              rd,
    input  logic                              wr,
    input  logic                              size,
    input  logic [cache_geom_pkg::ADDR_W-1:0] addr,
    input  logic [31:0]                       wdata,
    output logic                              stall,
    output logic [31:0]                       rdata,
    output logic                              mem_req,
    output logic                              mem_we,
    output logic [cache_geom_pkg::ADDR_W-1:0] mem_addr,
    output logic [31:0]                       mem_wdata,
    output logic                              mem_size,
    input  logic                              mem_done,
    input  cache_geom_pkg::line_data_t        mem_rline
);
    import cache_geom_pkg::*;
    import mem_bus_pkg::*;

    logic [TAG_W-1:0]   tag_mem  [2][SETS];
    line_data_t         data_mem [2][SETS];
    logic [SETS-1:0]    valid    [2];
    logic [SETS-1:0]    lru;            // way to replace next

    logic [TAG_W-1:0]   tag;
    logic [INDEX_W-1:0] index;
    logic [1:0]         way_hit;
    logic               hit;
    logic               hit_way;
    logic               fill_way;
    line_data_t         hit_line;
    line_data_t         merged;

    logic               busy;           // memory transaction outstanding
    logic               ack;            // completion cycle after done
    logic               need_mem;
    logic               fetch_done;
    logic               write_done;

    assign tag   = addr[ADDR_W-1 -: TAG_W];
    assign index = addr[OFFSET_W +: INDEX_W];

    always_comb begin
        for (int w = 0; w < 2; w++) begin
            way_hit[w] = valid[w][index] && (tag_mem[w][index] == tag);
        end
    end

    assign hit      = |way_hit;
    assign hit_way  = way_hit[1];
    assign fill_way = lru[index];
    assign hit_line = data_mem[hit_way][index];
    assign rdata    = hit_line.words[addr[2]];

    // store data folded into the hit line
    always_comb begin
        merged = hit_line;
        if (size == SIZE_WORD) begin
            merged.words[addr[2]] = wdata;
        end else begin
            merged.bytes[addr[OFFSET_W-1:0]] = wdata[7:0];
        end
    end

    assign need_mem   = wr || (rd && !hit);
    assign stall      = busy || (!ack && need_mem);
    assign fetch_done = busy && mem_done && !wr;
    assign write_done = busy && mem_done && wr;

    // request fields come straight from the held hart inputs
    assign mem_req   = busy;
    assign mem_we    = wr;
    assign mem_addr  = wr ? addr : {addr[ADDR_W-1:OFFSET_W], {OFFSET_W{1'b0}}};
    assign mem_wdata = wdata;
    assign mem_size  = size;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy <= 1'b0;
            ack  <= 1'b0;
        end else begin
            ack <= busy && mem_done;
            if (busy) begin
                if (mem_done) begin
                    busy <= 1'b0;
                end
            end else if (!ack && need_mem) begin
                busy <= 1'b1;   // req goes out next cycle
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid[0] <= '0;
            valid[1] <= '0;
            lru      <= '0;
        end else if (fetch_done) begin
            valid[fill_way][index] <= 1'b1;
            lru[index]             <= !fill_way;
        end else if (rd && hit && !busy) begin
            lru[index] <= !hit_way;   // other way is now older
        end
    end

    always_ff @(posedge clk) begin
        if (fetch_done) begin
            tag_mem[fill_way][index]  <= tag;
            data_mem[fill_way][index] <= mem_rline;
        end else if (write_done && hit) begin
            data_mem[hit_way][index] <= merged;
        end
    end

endmodule

// ==== logic/mem_arbiter.sv ====
// Round-robin arbiter between the two caches and main memory.
// A grant covers one whole transaction, from start until memory done.
// On a tie the port not served last wins. Done and the line go only
// to the granted port.

module mem_arbiter (
    input  logic                              clk,
    input  logic                              rst_n,
    input  logic                              req0,
    input  logic                              req1,
    input  logic                              we0,
    input  logic                              we1,
    input  logic [cache_geom_pkg::ADDR_W-1:0] addr0,
    input  logic [cache_geom_pkg::ADDR_W-1:0] addr1,
    input  logic [31:0]                       wdata0,
    input  logic [31:0]                       wdata1,
    input  logic                              size0,
    input  logic                              size1,
    output logic                              done0,
    output logic                              done1,
    output cache_geom_pkg::line_data_t        rline0,
    output cache_geom_pkg::line_data_t        rline1,
    output logic                              start,
    output logic                              we,
    output logic [cache_geom_pkg::ADDR_W-1:0] addr,
    output logic [31:0]                       wdata,
    output logic                              size,
    input  logic                              done,
    input  cache_geom_pkg::line_data_t        rline
);
    logic busy;
    logic grant;   // port currently owning memory
    logic prio;    // port that wins a tie
    logic pick;

    assign pick = (req0 && req1) ? prio : req1;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy  <= 1'b0;
            grant <= 1'b0;
            prio  <= 1'b0;
            start <= 1'b0;
        end else begin
            start <= 1'b0;
            if (busy) begin
                if (done) begin
                    busy <= 1'b0;
                    prio <= !grant;
                end
            end else if (req0 || req1) begin
                busy  <= 1'b1;
                grant <= pick;
                start <= 1'b1;
            end
        end
    end

    assign we    = grant ? we1 : we0;
    assign addr  = grant ? addr1 : addr0;
    assign wdata = grant ? wdata1 : wdata0;
    assign size  = grant ? size1 : size0;

    assign done0  = busy && done && !grant;
    assign done1  = busy && done && grant;
    assign rline0 = grant ? '0 : rline;
    assign rline1 = grant ? rline : '0;

endmodule

// ==== logic/main_memory.sv ====
// Byte-addressed main memory with a fixed access latency.
// A start pulse launches one access. Done pulses MEM_LATENCY cycles later,
// and the access happens then: a read returns the whole aligned line,
// a write stores one byte or one little-endian word. Contents start at zero.

module main_memory (
    input  logic                              clk,
    input  logic                              rst_n,
    input  logic                              start,
    input  logic                              we,
    input  logic                              size,
    input  logic [cache_geom_pkg::ADDR_W-1:0] addr,
    input  logic [31:0]                       wdata,
    output logic                              done,
    output cache_geom_pkg::line_data_t        rline
);
    import cache_geom_pkg::*;
    import mem_bus_pkg::*;

    logic [7:0]           mem [MEM_BYTES];
    logic [LAT_CNT_W-1:0] cnt;
    logic [ADDR_W-1:0]    base;

    initial begin
        for (int i = 0; i < MEM_BYTES; i++) begin
            mem[i] = 8'h00;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cnt <= '0;
        end else if (start) begin
            cnt <= LAT_CNT_W'(MEM_LATENCY);
        end else if (cnt != '0) begin
            cnt <= cnt - 1'b1;
        end
    end

    assign done = (cnt == LAT_CNT_W'(1));
    assign base = {addr[ADDR_W-1:OFFSET_W], {OFFSET_W{1'b0}}};

    always_comb begin
        for (int i = 0; i < LINE_BYTES; i++) begin
            rline.bytes[i] = mem[base | ADDR_W'(i)];
        end
    end

    always_ff @(posedge clk) begin
        if (done && we) begin
            if (size == SIZE_BYTE) begin
                mem[addr] <= wdata[7:0];
            end else begin
                for (int i = 0; i < 4; i++) begin
                    mem[addr | ADDR_W'(i)] <= wdata[8*i +: 8];   // addr word aligned
                end
            end
        end
    end

endmodule

// ==== logic/dual_port_dmem.sv ====
// Dual-port data memory for a two-hart core.
// Each hart port has a private write-through cache. Both caches share
// one main memory through a round-robin arbiter.

module dual_port_dmem (
    input  logic                              clk,
    input  logic                              rst_n,
    input  logic                              p0_rd,
    input  logic                              p0_wr,
    input  logic                              p0_size,
    input  logic [cache_geom_pkg::ADDR_W-1:0] p0_addr,
    input  logic [31:0]                       p0_wdata,
    output logic                              p0_stall,
    output logic [31:0]                       p0_rdata,
    input  logic                              p1_rd,
    input  logic                              p1_wr,
    input  logic                              p1_size,
    input  logic [cache_geom_pkg::ADDR_W-1:0] p1_addr,
    input  logic [31:0]                       p1_wdata,
    output logic                              p1_stall,
    output logic [31:0]                       p1_rdata
);
    import cache_geom_pkg::*;

    // cache side of the arbiter
    logic              c0_req, c0_we, c0_size, c0_done;
    logic              c1_req, c1_we, c1_size, c1_done;
    logic [ADDR_W-1:0] c0_addr, c1_addr;
    logic [31:0]       c0_wdata, c1_wdata;
    line_data_t        c0_rline, c1_rline;

    // memory side
    logic              m_start, m_we, m_size, m_done;
    logic [ADDR_W-1:0] m_addr;
    logic [31:0]       m_wdata;
    line_data_t        m_rline;

    data_cache_2way cache0 (
        .clk(clk), .rst_n(rst_n),
        .rd(p0_rd), .wr(p0_wr), .size(p0_size), .addr(p0_addr), .wdata(p0_wdata),
        .stall(p0_stall), .rdata(p0_rdata),
        .mem_req(c0_req), .mem_we(c0_we), .mem_addr(c0_addr),
        .mem_wdata(c0_wdata), .mem_size(c0_size),
        .mem_done(c0_done), .mem_rline(c0_rline)
    );

    data_cache_2way cache1 (
        .clk(clk), .rst_n(rst_n),
        .rd(p1_rd), .wr(p1_wr), .size(p1_size), .addr(p1_addr), .wdata(p1_wdata),
        .stall(p1_stall), .rdata(p1_rdata),
        .mem_req(c1_req), .mem_we(c1_we), .mem_addr(c1_addr),
        .mem_wdata(c1_wdata), .mem_size(c1_size),
        .mem_done(c1_done), .mem_rline(c1_rline)
    );

    mem_arbiter arbiter (
        .clk(clk), .rst_n(rst_n),
        .req0(c0_req), .req1(c1_req), .we0(c0_we), .we1(c1_we),
        .addr0(c0_addr), .addr1(c1_addr), .wdata0(c0_wdata), .wdata1(c1_wdata),
        .size0(c0_size), .size1(c1_size),
        .done0(c0_done), .done1(c1_done), .rline0(c0_rline), .rline1(c1_rline),
        .start(m_start), .we(m_we), .addr(m_addr), .wdata(m_wdata), .size(m_size),
        .done(m_done), .rline(m_rline)
    );

    main_memory memory (
        .clk(clk), .rst_n(rst_n),
        .start(m_start), .we(m_we), .size(m_size), .addr(m_addr), .wdata(m_wdata),
        .done(m_done), .rline(m_rline)
    );

endmodule

// ==== verification/dmem_checker.sv ====
// Watches both hart ports of the dual-port data memory.
// An access completes at a rising edge where rd or wr is high and stall is
// low. A read counts as a hit if stall never rose during the access.
// Reads are compared against the expected data and hit flag given by the
// testbench. The checker keeps pass and fail counts per port.

module dmem_checker (
    input  logic                              clk,
    input  logic                              rst_n,
    input  logic                              p0_rd,
    input  logic                              p0_wr,
    input  logic                              p0_stall,
    input  logic [cache_geom_pkg::ADDR_W-1:0] p0_addr,
    input  logic [31:0]                       p0_rdata,
    input  int                                p0_test,
    input  logic [31:0]                       p0_exp_rdata,
    input  logic                              p0_exp_hit,
    input  logic                              p1_rd,
    input  logic                              p1_wr,
    input  logic                              p1_stall,
    input  logic [cache_geom_pkg::ADDR_W-1:0] p1_addr,
    input  logic [31:0]                       p1_rdata,
    input  int                                p1_test,
    input  logic [31:0]                       p1_exp_rdata,
    input  logic                              p1_exp_hit,
    output int                                pass_count,
    output int                                fail_count
);
    import cache_geom_pkg::*;

    logic stalled0;   // stall seen since the access began
    logic stalled1;
    int   pass0, pass1, fail0, fail1;

    task automatic check_access(input int port, input int test, input logic is_read,
                                input logic [ADDR_W-1:0] addr, input logic [31:0] rdata,
                                input logic [31:0] exp_rdata, input logic hit,
                                input logic exp_hit, output logic ok);
        ok = 1'b1;
        if (is_read && rdata !== exp_rdata) begin
            $display("ERR t=%0t p%0d_rdata expected %h actual %h",
                     $time, port, exp_rdata, rdata);
            ok = 1'b0;
        end
        if (is_read && hit !== exp_hit) begin
            $display("ERR t=%0t p%0d_hit expected %b actual %b", $time, port, exp_hit, hit);
            ok = 1'b0;
        end
        $display("test %0d port %0d %s addr %h %s", test, port,
                 is_read ? "read " : "write", addr, ok ? "ok" : "failed");
    endtask

    always @(posedge clk or negedge rst_n) begin : watch_p0
        logic ok;
        if (!rst_n) begin
            stalled0 <= 1'b0;
            pass0    <= 0;
            fail0    <= 0;
        end else if (p0_rd || p0_wr) begin
            if (p0_stall) begin
                stalled0 <= 1'b1;
            end else begin
                check_access(0, p0_test, p0_rd, p0_addr, p0_rdata, p0_exp_rdata,
                             !stalled0, p0_exp_hit, ok);
                if (ok) begin
                    pass0 <= pass0 + 1;
                end else begin
                    fail0 <= fail0 + 1;
                end
                stalled0 <= 1'b0;   // next access starts clean
            end
        end
    end

    always @(posedge clk or negedge rst_n) begin : watch_p1
        logic ok;
        if (!rst_n) begin
            stalled1 <= 1'b0;
            pass1    <= 0;
            fail1    <= 0;
        end else if (p1_rd || p1_wr) begin
            if (p1_stall) begin
                stalled1 <= 1'b1;
            end else begin
                check_access(1, p1_test, p1_rd, p1_addr, p1_rdata, p1_exp_rdata,
                             !stalled1, p1_exp_hit, ok);
                if (ok) begin
                    pass1 <= pass1 + 1;
                end else begin
                    fail1 <= fail1 + 1;
                end
                stalled1 <= 1'b0;
            end
        end
    end

    assign pass_count = pass0 + pass1;
    assign fail_count = fail0 + fail1;

endmodule

// ==== verification/dual_port_dmem_tb.sv ====
// Testbench for the dual-port data memory.
// Reads access records from the test file, drives them onto the hart ports
// on falling edges and holds each request until stall drops at a rising
// edge. Records with mask 3 come in pairs and drive both ports together.
// The checker compares the results; the summary is printed here.

module dual_port_dmem_tb;
    import cache_geom_pkg::*;

    localparam int FIELDS     = 7;    // mask op size addr wdata expect hit
    localparam int MAX_RECS   = 64;
    localparam int WAIT_LIMIT = 50;   // cycles per access group

    logic              clk;
    logic              rst_n;
    logic              p0_rd, p0_wr, p0_size, p0_stall;
    logic              p1_rd, p1_wr, p1_size, p1_stall;
    logic [ADDR_W-1:0] p0_addr, p1_addr;
    logic [31:0]       p0_wdata, p1_wdata, p0_rdata, p1_rdata;
    int                p0_test, p1_test;
    logic [31:0]       p0_exp_rdata, p1_exp_rdata;
    logic              p0_exp_hit, p1_exp_hit;
    int                pass_count, fail_count;
    logic [31:0]       recs [FIELDS*MAX_RECS];
    logic              timed_out;

    dual_port_dmem dual_port_dmem_inst (
        .clk(clk), .rst_n(rst_n),
        .p0_rd(p0_rd), .p0_wr(p0_wr), .p0_size(p0_size), .p0_addr(p0_addr),
        .p0_wdata(p0_wdata), .p0_stall(p0_stall), .p0_rdata(p0_rdata),
        .p1_rd(p1_rd), .p1_wr(p1_wr), .p1_size(p1_size), .p1_addr(p1_addr),
        .p1_wdata(p1_wdata), .p1_stall(p1_stall), .p1_rdata(p1_rdata)
    );

    dmem_checker dmem_checker_inst (
        .clk(clk), .rst_n(rst_n),
        .p0_rd(p0_rd), .p0_wr(p0_wr), .p0_stall(p0_stall), .p0_addr(p0_addr),
        .p0_rdata(p0_rdata), .p0_test(p0_test), .p0_exp_rdata(p0_exp_rdata),
        .p0_exp_hit(p0_exp_hit),
        .p1_rd(p1_rd), .p1_wr(p1_wr), .p1_stall(p1_stall), .p1_addr(p1_addr),
        .p1_rdata(p1_rdata), .p1_test(p1_test), .p1_exp_rdata(p1_exp_rdata),
        .p1_exp_hit(p1_exp_hit),
        .pass_count(pass_count), .fail_count(fail_count)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic drive_port(input int port, input int rec);
        int b;
        b = rec * FIELDS;
        if (port == 0) begin
            p0_rd        = (recs[b+1] == 0);   // op 0 is a read
            p0_wr        = (recs[b+1] != 0);
            p0_size      = recs[b+2][0];
            p0_addr      = recs[b+3][ADDR_W-1:0];
            p0_wdata     = recs[b+4];
            p0_exp_rdata = recs[b+5];
            p0_exp_hit   = recs[b+6][0];
            p0_test      = rec;
        end else begin
            p1_rd        = (recs[b+1] == 0);
            p1_wr        = (recs[b+1] != 0);
            p1_size      = recs[b+2][0];
            p1_addr      = recs[b+3][ADDR_W-1:0];
            p1_wdata     = recs[b+4];
            p1_exp_rdata = recs[b+5];
            p1_exp_hit   = recs[b+6][0];
            p1_test      = rec;
        end
    endtask

    task automatic idle_port(input int port);
        if (port == 0) begin
            p0_rd = 1'b0;
            p0_wr = 1'b0;
        end else begin
            p1_rd = 1'b0;
            p1_wr = 1'b0;
        end
    endtask

    // each port is released on the falling edge after its completing edge
    task automatic run_group(input int r0, input int r1, input logic use0, input logic use1);
        int   cycles;
        logic pend0;
        logic pend1;
        @(negedge clk);
        if (use0) drive_port(0, r0);
        if (use1) drive_port(1, r1);
        pend0  = use0;
        pend1  = use1;
        cycles = 0;
        while ((pend0 || pend1) && cycles < WAIT_LIMIT) begin
            @(posedge clk);
            if (pend0 && !p0_stall) pend0 = 1'b0;
            if (pend1 && !p1_stall) pend1 = 1'b0;
            @(negedge clk);
            if (!pend0) idle_port(0);
            if (!pend1) idle_port(1);
            cycles++;
        end
        if (pend0) begin
            $display("port 0 did not finish its access to address %h in %0d cycles",
                     p0_addr, WAIT_LIMIT);
            timed_out = 1'b1;
        end
        if (pend1) begin
            $display("port 1 did not finish its access to address %h in %0d cycles",
                     p1_addr, WAIT_LIMIT);
            timed_out = 1'b1;
        end
    endtask

    initial begin
        int r;
        rst_n        = 1'b0;
        p0_rd        = 1'b0;
        p0_wr        = 1'b0;
        p0_size      = 1'b0;
        p0_addr      = '0;
        p0_wdata     = '0;
        p1_rd        = 1'b0;
        p1_wr        = 1'b0;
        p1_size      = 1'b0;
        p1_addr      = '0;
        p1_wdata     = '0;
        p0_test      = 0;
        p1_test      = 0;
        p0_exp_rdata = '0;
        p1_exp_rdata = '0;
        p0_exp_hit   = 1'b0;
        p1_exp_hit   = 1'b0;
        timed_out    = 1'b0;
        for (int i = 0; i < FIELDS*MAX_RECS; i++) begin
            recs[i] = '0;   // a zero mask ends the list
        end
        $readmemh("verification/dmem_tests.mem", recs);

        repeat (2) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        r = 0;
        while (r < MAX_RECS && recs[r*FIELDS] != 0 && !timed_out) begin
            if (recs[r*FIELDS] == 3) begin
                run_group(r, r + 1, 1'b1, 1'b1);
                r += 2;
            end else if (recs[r*FIELDS] == 2) begin
                run_group(0, r, 1'b0, 1'b1);
                r += 1;
            end else begin
                run_group(r, 0, 1'b1, 1'b0);
                r += 1;
            end
        end

        @(negedge clk);
        $display("tests passed %0d failed %0d of %0d", pass_count, fail_count, r);
        if (!timed_out && fail_count == 0 && pass_count == r) begin
            $display(">>> PASS");
        end else begin
            if (!timed_out && pass_count + fail_count != r) begin
                $display("checker saw %0d completed accesses but %0d were issued",
                         pass_count + fail_count, r);
            end
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

// ==== verification/dmem_tests.mem ====
// columns: mask op size addr wdata expect hit (op 0 read 1 write, size 0 word 1 byte)
// mask 1 port 0, mask 2 port 1, mask 3 pairs a port 0 line with the next port 1 line
1 1 0 00100 11223344 00000000 0
1 0 0 00100 00000000 11223344 0
1 0 0 00104 00000000 00000000 1
1 0 0 00100 00000000 11223344 1
1 1 1 00101 000000AA 00000000 0
1 1 1 00107 000000BB 00000000 0
1 0 0 00100 00000000 1122AA44 1
1 0 0 00104 00000000 BB000000 1
1 1 0 00A00 A0A0A0A0 00000000 0
1 1 0 01200 B0B0B0B0 00000000 0
1 1 0 01A00 C0C0C0C0 00000000 0
1 0 0 00A00 00000000 A0A0A0A0 0
1 0 0 01200 00000000 B0B0B0B0 0
1 0 0 00A00 00000000 A0A0A0A0 1
1 0 0 01A00 00000000 C0C0C0C0 0
1 0 0 00A00 00000000 A0A0A0A0 1
1 0 0 01200 00000000 B0B0B0B0 0
1 1 0 02300 DEADBEEF 00000000 0
1 0 0 02300 00000000 DEADBEEF 0
3 1 0 03000 0BADF00D 00000000 0
3 1 0 04008 13579BDF 00000000 0
3 0 0 03000 00000000 0BADF00D 0
3 0 0 04008 00000000 13579BDF 0
2 0 0 00100 00000000 1122AA44 0
2 0 0 00104 00000000 BB000000 1
1 0 0 04008 00000000 13579BDF 0
0 0 0 00000 00000000 00000000 0

// ==== flist.f ====
logic/cache_geom_pkg.sv
logic/mem_bus_pkg.sv
logic/data_cache_2way.sv
logic/mem_arbiter.sv
logic/main_memory.sv
logic/dual_port_dmem.sv
verification/dmem_checker.sv
verification/dual_port_dmem_tb.sv

// ==== Makefile ====
# Verilator build and run of the dual-port data memory testbench

SRCS := $(shell cat flist.f)
BIN  := obj_dir/Vdual_port_dmem_tb

.PHONY: all run clean

all: run

$(BIN): flist.f $(SRCS)
	verilator --binary --timing -j 0 --top-module dual_port_dmem_tb -f flist.f

run: $(BIN) verification/dmem_tests.mem
	./$(BIN) | tee sim.log
	grep -qxF '>>> PASS' sim.log

clean:
	rm -rf obj_dir sim.log
